//--- hdl/la_isa_pkg.sv
package la_isa_pkg;

    typedef logic [31:0] inst_t;
    typedef logic [31:0] addr_t;      // pc or immediate value
    typedef logic [4:0]  arf_id_t;

    typedef enum logic [2:0] {IMM_S12, IMM_U12, IMM_U5, IMM_U20, IMM_NONE} imm_type_t;
    typedef enum logic [1:0] {ADDR_S12, ADDR_S16, ADDR_S26, ADDR_NONE} addr_imm_type_t;
    typedef enum logic [2:0] {REG_ZERO, REG_RD, REG_RJ, REG_RK, REG_IMM} reg_r_sel_t;
    typedef enum logic [1:0] {REG_W_NONE, REG_W_RD, REG_W_R1} reg_w_sel_t;

    // number of fixed opcode bits, counted down from bit 31
    localparam int OPW_3R    = 17;    // 3R, shift by imm, syscall, break
    localparam int OPW_2RI12 = 10;
    localparam int OPW_1RI20 = 7;
    localparam int OPW_BR    = 6;     // offs16 and offs26 forms

    localparam inst_t OP_ADD_W     = 32'h0010_0000;
    localparam inst_t OP_SUB_W     = 32'h0011_0000;
    localparam inst_t OP_SLT       = 32'h0012_0000;
    localparam inst_t OP_SLTU      = 32'h0012_8000;
    localparam inst_t OP_NOR       = 32'h0014_0000;
    localparam inst_t OP_AND       = 32'h0014_8000;
    localparam inst_t OP_OR        = 32'h0015_0000;
    localparam inst_t OP_XOR       = 32'h0015_8000;
    localparam inst_t OP_SLL_W     = 32'h0017_0000;
    localparam inst_t OP_SRL_W     = 32'h0017_8000;
    localparam inst_t OP_SRA_W     = 32'h0018_0000;
    localparam inst_t OP_BREAK     = 32'h002a_0000;
    localparam inst_t OP_SYSCALL   = 32'h002b_0000;
    localparam inst_t OP_SLLI_W    = 32'h0040_8000;
    localparam inst_t OP_SRLI_W    = 32'h0044_8000;
    localparam inst_t OP_SRAI_W    = 32'h0048_8000;
    localparam inst_t OP_SLTI      = 32'h0200_0000;
    localparam inst_t OP_SLTUI     = 32'h0240_0000;
    localparam inst_t OP_ADDI_W    = 32'h0280_0000;
    localparam inst_t OP_ANDI      = 32'h0340_0000;
    localparam inst_t OP_ORI       = 32'h0380_0000;
    localparam inst_t OP_XORI      = 32'h03c0_0000;
    localparam inst_t OP_LU12I_W   = 32'h1400_0000;
    localparam inst_t OP_PCADDU12I = 32'h1c00_0000;
    localparam inst_t OP_LD_B      = 32'h2800_0000;
    localparam inst_t OP_LD_H      = 32'h2840_0000;
    localparam inst_t OP_LD_W      = 32'h2880_0000;
    localparam inst_t OP_ST_B      = 32'h2900_0000;
    localparam inst_t OP_ST_H      = 32'h2940_0000;
    localparam inst_t OP_ST_W      = 32'h2980_0000;
    localparam inst_t OP_LD_BU     = 32'h2a00_0000;
    localparam inst_t OP_LD_HU     = 32'h2a40_0000;
    localparam inst_t OP_JIRL      = 32'h4c00_0000;
    localparam inst_t OP_B         = 32'h5000_0000;
    localparam inst_t OP_BL        = 32'h5400_0000;
    localparam inst_t OP_BEQ       = 32'h5800_0000;
    localparam inst_t OP_BNE       = 32'h5c00_0000;
    localparam inst_t OP_BLT       = 32'h6000_0000;
    localparam inst_t OP_BGE       = 32'h6400_0000;
    localparam inst_t OP_BLTU      = 32'h6800_0000;
    localparam inst_t OP_BGEU      = 32'h6c00_0000;

    // compare only the top width bits of the word
    function automatic logic op_match(inst_t inst, inst_t op, int width);
        inst_t mask;
        mask = ~(32'hffff_ffff >> width);
        return (inst & mask) == op;
    endfunction

endpackage

//--- hdl/decode_pkg.sv
package decode_pkg;

    localparam int SLOTS     = 2;     // instructions per packet
    localparam int BUF_DEPTH = 2;     // packets held by the stage

    typedef logic [$clog2(BUF_DEPTH)-1:0]   buf_ptr_t;
    typedef logic [$clog2(BUF_DEPTH+1)-1:0] buf_cnt_t;

    typedef enum logic [1:0] {FU_ALU, FU_LSU, FU_BRU, FU_SYS} fu_type_t;

    typedef enum logic [3:0] {
        ADD, SUB, SLT, SLTU, AND, OR, NOR, XOR, SLL, SRL, SRA, LUI
    } alu_op_t;

    typedef enum logic [2:0] {
        BR_NONE, BEQ, BNE, BLT, BGE, BLTU, BGEU, BR_ALWAYS
    } br_cond_t;

    // access width of loads and stores
    typedef logic [1:0] mem_size_t;
    localparam mem_size_t MEM_BYTE = 2'd0;
    localparam mem_size_t MEM_HALF = 2'd1;
    localparam mem_size_t MEM_WORD = 2'd2;

endpackage

//--- hdl/basic_decoder.sv
`timescale 1ns/1ps

module basic_decoder (
    input  la_isa_pkg::inst_t          inst,
    output la_isa_pkg::reg_r_sel_t     reg_r0_sel,
    output la_isa_pkg::reg_r_sel_t     reg_r1_sel,
    output la_isa_pkg::reg_w_sel_t     reg_w_sel,
    output la_isa_pkg::imm_type_t      imm_type,
    output la_isa_pkg::addr_imm_type_t addr_imm_type,
    output decode_pkg::fu_type_t       fu_type,
    output decode_pkg::alu_op_t        alu_op,
    output decode_pkg::mem_size_t      mem_size,
    output logic                       mem_signed,
    output logic                       mem_write,
    output decode_pkg::br_cond_t       br_cond,
    output logic                       syscall,
    output logic                       brk,
    output logic                       decode_err
);
    import la_isa_pkg::*;
    import decode_pkg::*;

    logic is_add_w, is_sub_w, is_slt, is_sltu, is_and, is_or, is_nor, is_xor;
    logic is_sll_w, is_srl_w, is_sra_w, is_slli_w, is_srli_w, is_srai_w;
    logic is_addi_w, is_slti, is_sltui, is_andi, is_ori, is_xori;
    logic is_lu12i_w, is_pcaddu12i, is_syscall, is_break;
    logic is_ld_b, is_ld_h, is_ld_w, is_ld_bu, is_ld_hu, is_st_b, is_st_h, is_st_w;
    logic is_beq, is_bne, is_blt, is_bge, is_bltu, is_bgeu, is_b, is_bl, is_jirl;
    // instruction forms
    logic f_rr, f_ri5, f_ri12s, f_ri12u, f_ri20, f_imm, f_load, f_store, f_bcc, f_jump;

    assign is_add_w     = op_match(inst, OP_ADD_W, OPW_3R);
    assign is_sub_w     = op_match(inst, OP_SUB_W, OPW_3R);
    assign is_slt       = op_match(inst, OP_SLT, OPW_3R);
    assign is_sltu      = op_match(inst, OP_SLTU, OPW_3R);
    assign is_and       = op_match(inst, OP_AND, OPW_3R);
    assign is_or        = op_match(inst, OP_OR, OPW_3R);
    assign is_nor       = op_match(inst, OP_NOR, OPW_3R);
    assign is_xor       = op_match(inst, OP_XOR, OPW_3R);
    assign is_sll_w     = op_match(inst, OP_SLL_W, OPW_3R);
    assign is_srl_w     = op_match(inst, OP_SRL_W, OPW_3R);
    assign is_sra_w     = op_match(inst, OP_SRA_W, OPW_3R);
    assign is_slli_w    = op_match(inst, OP_SLLI_W, OPW_3R);
    assign is_srli_w    = op_match(inst, OP_SRLI_W, OPW_3R);
    assign is_srai_w    = op_match(inst, OP_SRAI_W, OPW_3R);
    assign is_syscall   = op_match(inst, OP_SYSCALL, OPW_3R);   // code field ignored
    assign is_break     = op_match(inst, OP_BREAK, OPW_3R);
    assign is_addi_w    = op_match(inst, OP_ADDI_W, OPW_2RI12);
    assign is_slti      = op_match(inst, OP_SLTI, OPW_2RI12);
    assign is_sltui     = op_match(inst, OP_SLTUI, OPW_2RI12);
    assign is_andi      = op_match(inst, OP_ANDI, OPW_2RI12);
    assign is_ori       = op_match(inst, OP_ORI, OPW_2RI12);
    assign is_xori      = op_match(inst, OP_XORI, OPW_2RI12);
    assign is_ld_b      = op_match(inst, OP_LD_B, OPW_2RI12);
    assign is_ld_h      = op_match(inst, OP_LD_H, OPW_2RI12);
    assign is_ld_w      = op_match(inst, OP_LD_W, OPW_2RI12);
    assign is_ld_bu     = op_match(inst, OP_LD_BU, OPW_2RI12);
    assign is_ld_hu     = op_match(inst, OP_LD_HU, OPW_2RI12);
    assign is_st_b      = op_match(inst, OP_ST_B, OPW_2RI12);
    assign is_st_h      = op_match(inst, OP_ST_H, OPW_2RI12);
    assign is_st_w      = op_match(inst, OP_ST_W, OPW_2RI12);
    assign is_lu12i_w   = op_match(inst, OP_LU12I_W, OPW_1RI20);
    assign is_pcaddu12i = op_match(inst, OP_PCADDU12I, OPW_1RI20);
    assign is_jirl      = op_match(inst, OP_JIRL, OPW_BR);
    assign is_b         = op_match(inst, OP_B, OPW_BR);
    assign is_bl        = op_match(inst, OP_BL, OPW_BR);
    assign is_beq       = op_match(inst, OP_BEQ, OPW_BR);
    assign is_bne       = op_match(inst, OP_BNE, OPW_BR);
    assign is_blt       = op_match(inst, OP_BLT, OPW_BR);
    assign is_bge       = op_match(inst, OP_BGE, OPW_BR);
    assign is_bltu      = op_match(inst, OP_BLTU, OPW_BR);
    assign is_bgeu      = op_match(inst, OP_BGEU, OPW_BR);

    assign f_rr    = is_add_w | is_sub_w | is_slt | is_sltu | is_and | is_or | is_nor
                   | is_xor | is_sll_w | is_srl_w | is_sra_w;
    assign f_ri5   = is_slli_w | is_srli_w | is_srai_w;
    assign f_ri12s = is_addi_w | is_slti | is_sltui;
    assign f_ri12u = is_andi | is_ori | is_xori;       // logic ops zero-extend
    assign f_ri20  = is_lu12i_w | is_pcaddu12i;
    assign f_imm   = f_ri5 | f_ri12s | f_ri12u | f_ri20;
    assign f_load  = is_ld_b | is_ld_h | is_ld_w | is_ld_bu | is_ld_hu;
    assign f_store = is_st_b | is_st_h | is_st_w;
    assign f_bcc   = is_beq | is_bne | is_blt | is_bge | is_bltu | is_bgeu;
    assign f_jump  = is_b | is_bl | is_jirl;

    assign decode_err = !(f_rr | f_imm | f_load | f_store | f_bcc | f_jump
                          | is_syscall | is_break);

    assign fu_type = (f_load | f_store) ? FU_LSU :
                     (f_bcc | f_jump)   ? FU_BRU :
                     (f_rr | f_imm)     ? FU_ALU : FU_SYS;

    assign reg_r0_sel = (f_rr | f_ri5 | f_ri12s | f_ri12u | f_load | f_store | f_bcc | is_jirl)
                        ? REG_RJ : REG_ZERO;
    assign reg_r1_sel = f_rr              ? REG_RK  :
                        f_imm             ? REG_IMM :
                        (f_store | f_bcc) ? REG_RD  : REG_ZERO;   // store data, compare operand
    assign reg_w_sel  = (f_rr | f_imm | f_load | is_jirl) ? REG_W_RD :
                        is_bl                             ? REG_W_R1 : REG_W_NONE;

    assign imm_type = f_ri12s ? IMM_S12 :
                      f_ri12u ? IMM_U12 :
                      f_ri5   ? IMM_U5  :
                      f_ri20  ? IMM_U20 : IMM_NONE;
    assign addr_imm_type = (f_load | f_store) ? ADDR_S12 :
                           (f_bcc | is_jirl)  ? ADDR_S16 :
                           (is_b | is_bl)     ? ADDR_S26 : ADDR_NONE;

    always_comb begin
        alu_op = ADD;   // also address and link arithmetic
        if (is_sub_w) alu_op = SUB;
        else if (is_slt | is_slti) alu_op = SLT;
        else if (is_sltu | is_sltui) alu_op = SLTU;
        else if (is_and | is_andi) alu_op = AND;
        else if (is_or | is_ori) alu_op = OR;
        else if (is_nor) alu_op = NOR;
        else if (is_xor | is_xori) alu_op = XOR;
        else if (is_sll_w | is_slli_w) alu_op = SLL;
        else if (is_srl_w | is_srli_w) alu_op = SRL;
        else if (is_sra_w | is_srai_w) alu_op = SRA;
        else if (is_lu12i_w) alu_op = LUI;
    end

    assign br_cond = is_beq  ? BEQ  :
                     is_bne  ? BNE  :
                     is_blt  ? BLT  :
                     is_bge  ? BGE  :
                     is_bltu ? BLTU :
                     is_bgeu ? BGEU :
                     f_jump  ? BR_ALWAYS : BR_NONE;

    assign mem_size   = (is_ld_b | is_ld_bu | is_st_b) ? MEM_BYTE :
                        (is_ld_h | is_ld_hu | is_st_h) ? MEM_HALF :
                        (is_ld_w | is_st_w)            ? MEM_WORD : MEM_BYTE;
    assign mem_signed = is_ld_b | is_ld_h;
    assign mem_write  = f_store;
    assign syscall    = is_syscall;
    assign brk        = is_break;

endmodule

//--- hdl/imm_gen.sv
`timescale 1ns/1ps

module imm_gen (
    input  la_isa_pkg::inst_t          inst,
    input  la_isa_pkg::imm_type_t      imm_type,
    input  la_isa_pkg::addr_imm_type_t addr_imm_type,
    output la_isa_pkg::addr_t          data_imm,
    output la_isa_pkg::addr_t          addr_imm
);
    import la_isa_pkg::*;

    always_comb begin
        case (imm_type)
            IMM_S12: data_imm = {{20{inst[21]}}, inst[21:10]};
            IMM_U12: data_imm = {20'b0, inst[21:10]};
            IMM_U5:  data_imm = {27'b0, inst[14:10]};     // shift amount
            IMM_U20: data_imm = {inst[24:5], 12'b0};      // lu12i.w, pcaddu12i
            default: data_imm = '0;
        endcase
    end

    always_comb begin
        case (addr_imm_type)
            ADDR_S12: addr_imm = {{20{inst[21]}}, inst[21:10]};           // byte offset
            ADDR_S16: addr_imm = {{14{inst[25]}}, inst[25:10], 2'b0};
            // offs26 keeps its high part in [9:0]
            ADDR_S26: addr_imm = {{4{inst[9]}}, inst[9:0], inst[25:10], 2'b0};
            default:  addr_imm = '0;
        endcase
    end

endmodule

//--- hdl/decoder.sv
`timescale 1ns/1ps

module decoder (
    input  la_isa_pkg::addr_t                             head_pc,
    input  la_isa_pkg::inst_t [decode_pkg::SLOTS-1:0]     head_insts,
    input  logic [decode_pkg::SLOTS-1:0]                  head_mask,
    output logic [decode_pkg::SLOTS-1:0]                  out_mask,
    output la_isa_pkg::addr_t [decode_pkg::SLOTS-1:0]     out_pc,
    output la_isa_pkg::arf_id_t [2*decode_pkg::SLOTS-1:0] out_r_arfid,
    output la_isa_pkg::arf_id_t [decode_pkg::SLOTS-1:0]   out_w_arfid,
    output logic [decode_pkg::SLOTS-1:0]                  out_w_reg,
    output logic [2*decode_pkg::SLOTS-1:0]                out_use_imm,
    output la_isa_pkg::addr_t [decode_pkg::SLOTS-1:0]     out_data_imm,
    output la_isa_pkg::addr_t [decode_pkg::SLOTS-1:0]     out_addr_imm,
    output decode_pkg::fu_type_t [decode_pkg::SLOTS-1:0]  out_fu_type,
    output decode_pkg::alu_op_t [decode_pkg::SLOTS-1:0]   out_alu_op,
    output decode_pkg::mem_size_t [decode_pkg::SLOTS-1:0] out_mem_size,
    output logic [decode_pkg::SLOTS-1:0]                  out_mem_signed,
    output logic [decode_pkg::SLOTS-1:0]                  out_mem_write,
    output decode_pkg::br_cond_t [decode_pkg::SLOTS-1:0]  out_br_cond,
    output logic [decode_pkg::SLOTS-1:0]                  out_syscall,
    output logic [decode_pkg::SLOTS-1:0]                  out_break,
    output logic [decode_pkg::SLOTS-1:0]                  out_decode_err
);
    import la_isa_pkg::*;
    import decode_pkg::*;

    // rd at [4:0], rj at [9:5], rk at [14:10]
    function automatic arf_id_t pick_reg(reg_r_sel_t sel, inst_t inst);
        case (sel)
            REG_RD:  return inst[4:0];
            REG_RJ:  return inst[9:5];
            REG_RK:  return inst[14:10];
            default: return '0;    // zero and imm operands read r0
        endcase
    endfunction

    assign out_mask = head_mask;   // masked-off slots still decode

    for (genvar i = 0; i < SLOTS; i++) begin : g_slot
        reg_r_sel_t     r0_sel;
        reg_r_sel_t     r1_sel;
        reg_w_sel_t     w_sel;
        imm_type_t      imm_type;
        addr_imm_type_t addr_imm_type;

        assign out_pc[i] = head_pc | addr_t'(4 * i);   // packet pc is 8-byte aligned

        basic_decoder u_basic (
            .inst          (head_insts[i]),
            .reg_r0_sel    (r0_sel),
            .reg_r1_sel    (r1_sel),
            .reg_w_sel     (w_sel),
            .imm_type      (imm_type),
            .addr_imm_type (addr_imm_type),
            .fu_type       (out_fu_type[i]),
            .alu_op        (out_alu_op[i]),
            .mem_size      (out_mem_size[i]),
            .mem_signed    (out_mem_signed[i]),
            .mem_write     (out_mem_write[i]),
            .br_cond       (out_br_cond[i]),
            .syscall       (out_syscall[i]),
            .brk           (out_break[i]),
            .decode_err    (out_decode_err[i])
        );

        imm_gen u_imm (
            .inst          (head_insts[i]),
            .imm_type      (imm_type),
            .addr_imm_type (addr_imm_type),
            .data_imm      (out_data_imm[i]),
            .addr_imm      (out_addr_imm[i])
        );

        assign out_r_arfid[2*i]   = pick_reg(r0_sel, head_insts[i]);
        assign out_r_arfid[2*i+1] = pick_reg(r1_sel, head_insts[i]);
        assign out_use_imm[2*i]   = (r0_sel == REG_IMM);
        assign out_use_imm[2*i+1] = (r1_sel == REG_IMM);

        assign out_w_reg[i]   = (w_sel != REG_W_NONE);
        assign out_w_arfid[i] = (w_sel == REG_W_RD) ? head_insts[i][4:0] :
                                (w_sel == REG_W_R1) ? arf_id_t'(1) : '0;   // r1 is the bl link
    end

endmodule

//--- hdl/decode_ctrl.sv
`timescale 1ns/1ps

module decode_ctrl (
    input  logic                                      clk,
    input  logic                                      rst_n,
    input  logic                                      in_valid,
    output logic                                      in_ready,
    input  la_isa_pkg::addr_t                         in_pc,
    input  la_isa_pkg::inst_t [decode_pkg::SLOTS-1:0] in_insts,
    input  logic [decode_pkg::SLOTS-1:0]              in_mask,
    output logic                                      out_valid,
    input  logic                                      out_ready,
    output la_isa_pkg::addr_t                         head_pc,
    output la_isa_pkg::inst_t [decode_pkg::SLOTS-1:0] head_insts,
    output logic [decode_pkg::SLOTS-1:0]              head_mask
);
    import la_isa_pkg::*;
    import decode_pkg::*;

    // raw packet store, decoded at the head only
    addr_t             pc_mem   [BUF_DEPTH];
    inst_t [SLOTS-1:0] inst_mem [BUF_DEPTH];
    logic  [SLOTS-1:0] mask_mem [BUF_DEPTH];

    buf_ptr_t rd_ptr;
    buf_ptr_t wr_ptr;
    buf_cnt_t count;
    buf_cnt_t count_next;
    logic     push;
    logic     pop;

    assign push      = in_valid & in_ready;
    assign pop       = out_valid & out_ready;
    assign out_valid = (count != '0);

    always_comb begin
        count_next = count;
        if (push && !pop)
            count_next = count + 1'b1;
        else if (pop && !push)
            count_next = count - 1'b1;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_ptr   <= '0;
            wr_ptr   <= '0;
            count    <= '0;
            in_ready <= 1'b1;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == buf_ptr_t'(BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == buf_ptr_t'(BUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            count    <= count_next;
            in_ready <= (count_next < buf_cnt_t'(BUF_DEPTH));   // room for one more
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            pc_mem[wr_ptr]   <= in_pc;
            inst_mem[wr_ptr] <= in_insts;
            mask_mem[wr_ptr] <= in_mask;
        end
    end

    // held steady until popped
    assign head_pc    = pc_mem[rd_ptr];
    assign head_insts = inst_mem[rd_ptr];
    assign head_mask  = mask_mem[rd_ptr];

endmodule

//--- hdl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                                          clk,
    input  logic                                          rst_n,
    input  logic                                          in_valid,
    output logic                                          in_ready,
    input  la_isa_pkg::addr_t                             in_pc,
    input  la_isa_pkg::inst_t [decode_pkg::SLOTS-1:0]     in_insts,
    input  logic [decode_pkg::SLOTS-1:0]                  in_mask,
    output logic                                          out_valid,
    input  logic                                          out_ready,
    output logic [decode_pkg::SLOTS-1:0]                  out_mask,
    output la_isa_pkg::addr_t [decode_pkg::SLOTS-1:0]     out_pc,
    output la_isa_pkg::arf_id_t [2*decode_pkg::SLOTS-1:0] out_r_arfid,
    output la_isa_pkg::arf_id_t [decode_pkg::SLOTS-1:0]   out_w_arfid,
    output logic [decode_pkg::SLOTS-1:0]                  out_w_reg,
    output logic [2*decode_pkg::SLOTS-1:0]                out_use_imm,
    output la_isa_pkg::addr_t [decode_pkg::SLOTS-1:0]     out_data_imm,
    output la_isa_pkg::addr_t [decode_pkg::SLOTS-1:0]     out_addr_imm,
    output decode_pkg::fu_type_t [decode_pkg::SLOTS-1:0]  out_fu_type,
    output decode_pkg::alu_op_t [decode_pkg::SLOTS-1:0]   out_alu_op,
    output decode_pkg::mem_size_t [decode_pkg::SLOTS-1:0] out_mem_size,
    output logic [decode_pkg::SLOTS-1:0]                  out_mem_signed,
    output logic [decode_pkg::SLOTS-1:0]                  out_mem_write,
    output decode_pkg::br_cond_t [decode_pkg::SLOTS-1:0]  out_br_cond,
    output logic [decode_pkg::SLOTS-1:0]                  out_syscall,
    output logic [decode_pkg::SLOTS-1:0]                  out_break,
    output logic [decode_pkg::SLOTS-1:0]                  out_decode_err
);
    import la_isa_pkg::*;
    import decode_pkg::*;

    // head packet of the buffer
    addr_t             head_pc;
    inst_t [SLOTS-1:0] head_insts;
    logic  [SLOTS-1:0] head_mask;

    decode_ctrl u_ctrl (
        .clk, .rst_n,
        .in_valid, .in_ready, .in_pc, .in_insts, .in_mask,
        .out_valid, .out_ready,
        .head_pc, .head_insts, .head_mask
    );

    // bundle fields come straight off the head entry
    decoder u_decoder (
        .head_pc, .head_insts, .head_mask,
        .out_mask, .out_pc, .out_r_arfid, .out_w_arfid, .out_w_reg, .out_use_imm,
        .out_data_imm, .out_addr_imm, .out_fu_type, .out_alu_op,
        .out_mem_size, .out_mem_signed, .out_mem_write,
        .out_br_cond, .out_syscall, .out_break, .out_decode_err
    );

endmodule

//--- bench/la_ref_model.svh
`ifndef LA_REF_MODEL_SVH
`define LA_REF_MODEL_SVH

// expected bundle of one slot
typedef struct packed {
    logic [31:0] pc;
    logic [4:0]  r0;
    logic [4:0]  r1;
    logic [4:0]  w_id;
    logic        w_reg;
    logic [1:0]  use_imm;     // bit 1 belongs to the second read operand
    logic [31:0] data_imm;
    logic [31:0] addr_imm;
    logic [1:0]  fu;
    logic [3:0]  alu;
    logic [1:0]  msize;
    logic        msigned;
    logic        mwrite;
    logic [2:0]  br;
    logic        sys;
    logic        brk;
    logic        err;
} exp_slot_t;

// 16 ops with 17 opcode bits, then 14 with 10, 2 with 7 and 9 with 6
localparam inst_t LEGAL_OPS [41] = '{
    32'h0010_0000, 32'h0011_0000, 32'h0012_0000, 32'h0012_8000, 32'h0014_0000,
    32'h0014_8000, 32'h0015_0000, 32'h0015_8000, 32'h0017_0000, 32'h0017_8000,
    32'h0018_0000, 32'h002a_0000, 32'h002b_0000, 32'h0040_8000, 32'h0044_8000,
    32'h0048_8000,
    32'h0200_0000, 32'h0240_0000, 32'h0280_0000, 32'h0340_0000, 32'h0380_0000,
    32'h03c0_0000, 32'h2800_0000, 32'h2840_0000, 32'h2880_0000, 32'h2900_0000,
    32'h2940_0000, 32'h2980_0000, 32'h2a00_0000, 32'h2a40_0000,
    32'h1400_0000, 32'h1c00_0000,
    32'h4c00_0000, 32'h5000_0000, 32'h5400_0000, 32'h5800_0000, 32'h5c00_0000,
    32'h6000_0000, 32'h6400_0000, 32'h6800_0000, 32'h6c00_0000
};

function automatic int op_width(int idx);
    return (idx < 16) ? 17 : (idx < 30) ? 10 : (idx < 32) ? 7 : 6;
endfunction

// legal word with random operand fields
function automatic inst_t gen_legal(logic [31:0] r_idx, logic [31:0] r_fields);
    int    idx;
    inst_t low_mask;
    idx      = int'(r_idx % 32'd41);
    low_mask = 32'hffff_ffff >> op_width(idx);
    return LEGAL_OPS[idx] | (r_fields & low_mask);
endfunction

function automatic exp_slot_t ref_decode(inst_t w, addr_t pc);
    exp_slot_t   e;
    logic [16:0] op17;
    logic [9:0]  op10;
    logic [6:0]  op7;
    logic [5:0]  op6;
    logic [31:0] s12;
    e     = '0;
    e.pc  = pc;
    e.fu  = FU_SYS;
    e.err = 1'b1;
    op17  = w[31:15];
    op10  = w[31:22];
    op7   = w[31:25];
    op6   = w[31:26];
    s12   = {{20{w[21]}}, w[21:10]};
    if (op17 inside {17'h20, 17'h22, 17'h24, 17'h25, 17'h28, 17'h29, 17'h2a, 17'h2b,
                     17'h2e, 17'h2f, 17'h30}) begin
        {e.err, e.fu, e.r0, e.r1, e.w_reg, e.w_id} = {1'b0, FU_ALU, w[9:5], w[14:10], 1'b1, w[4:0]};
        case (op17)
            17'h22: e.alu = SUB;
            17'h24: e.alu = SLT;
            17'h25: e.alu = SLTU;
            17'h28: e.alu = NOR;
            17'h29: e.alu = AND;
            17'h2a: e.alu = OR;
            17'h2b: e.alu = XOR;
            17'h2e: e.alu = SLL;
            17'h2f: e.alu = SRL;
            17'h30: e.alu = SRA;
            default: e.alu = ADD;
        endcase
    end else if (op17 inside {17'h81, 17'h89, 17'h91}) begin
        {e.err, e.fu, e.r0, e.w_reg, e.w_id} = {1'b0, FU_ALU, w[9:5], 1'b1, w[4:0]};
        e.use_imm  = 2'b10;
        e.data_imm = {27'b0, w[14:10]};
        e.alu      = (op17 == 17'h81) ? SLL : (op17 == 17'h89) ? SRL : SRA;
    end else if (op17 == 17'h54 || op17 == 17'h56) begin
        e.err = 1'b0;
        e.brk = (op17 == 17'h54);
        e.sys = (op17 == 17'h56);
    end else if (op10 inside {10'h008, 10'h009, 10'h00a, 10'h00d, 10'h00e, 10'h00f}) begin
        {e.err, e.fu, e.r0, e.w_reg, e.w_id} = {1'b0, FU_ALU, w[9:5], 1'b1, w[4:0]};
        e.use_imm  = 2'b10;
        e.data_imm = (op10 < 10'h00d) ? s12 : {20'b0, w[21:10]};   // logic ops zero-extend
        case (op10)
            10'h008: e.alu = SLT;
            10'h009: e.alu = SLTU;
            10'h00d: e.alu = AND;
            10'h00e: e.alu = OR;
            10'h00f: e.alu = XOR;
            default: e.alu = ADD;
        endcase
    end else if (op10 inside {10'h0a0, 10'h0a1, 10'h0a2, 10'h0a8, 10'h0a9}) begin
        {e.err, e.fu, e.r0, e.w_reg, e.w_id} = {1'b0, FU_LSU, w[9:5], 1'b1, w[4:0]};
        e.addr_imm = s12;
        e.msize    = (op10[1:0] == 2'd0) ? MEM_BYTE : (op10[1:0] == 2'd1) ? MEM_HALF : MEM_WORD;
        e.msigned  = (op10 == 10'h0a0) || (op10 == 10'h0a1);
    end else if (op10 inside {10'h0a4, 10'h0a5, 10'h0a6}) begin
        {e.err, e.fu, e.r0, e.r1} = {1'b0, FU_LSU, w[9:5], w[4:0]};
        e.addr_imm = s12;
        e.msize    = op10[1:0];
        e.mwrite   = 1'b1;
    end else if (op7 == 7'h0a || op7 == 7'h0e) begin
        {e.err, e.fu, e.w_reg, e.w_id} = {1'b0, FU_ALU, 1'b1, w[4:0]};
        e.use_imm  = 2'b10;
        e.data_imm = {w[24:5], 12'b0};
        e.alu      = (op7 == 7'h0a) ? LUI : ADD;
    end else if (op6 >= 6'h13 && op6 <= 6'h1b) begin
        e.err = 1'b0;
        e.fu  = FU_BRU;
        if (op6 == 6'h14 || op6 == 6'h15) begin
            e.addr_imm = {{4{w[9]}}, w[9:0], w[25:10], 2'b0};
            e.br       = BR_ALWAYS;
            if (op6 == 6'h15) {e.w_reg, e.w_id} = {1'b1, 5'd1};   // bl links into r1
        end else begin
            e.addr_imm = {{14{w[25]}}, w[25:10], 2'b0};
            e.r0       = w[9:5];
            if (op6 == 6'h13) begin
                {e.br, e.w_reg, e.w_id} = {BR_ALWAYS, 1'b1, w[4:0]};
            end else begin
                e.r1 = w[4:0];
                e.br = 3'(op6 - 6'h15);   // beq..bgeu in enum order
            end
        end
    end
    return e;
endfunction

`endif

//--- bench/decode_stage_tb.sv
`timescale 1ns/1ps

module decode_stage_tb;
    import la_isa_pkg::*;
    import decode_pkg::*;

    logic clk;
    logic rst_n;
    logic in_valid;
    logic in_ready;
    addr_t in_pc;
    inst_t [SLOTS-1:0] in_insts;
    logic [SLOTS-1:0] in_mask;
    logic out_valid;
    logic out_ready;
    logic [SLOTS-1:0] out_mask;
    addr_t [SLOTS-1:0] out_pc;
    arf_id_t [2*SLOTS-1:0] out_r_arfid;
    arf_id_t [SLOTS-1:0] out_w_arfid;
    logic [SLOTS-1:0] out_w_reg;
    logic [2*SLOTS-1:0] out_use_imm;
    addr_t [SLOTS-1:0] out_data_imm;
    addr_t [SLOTS-1:0] out_addr_imm;
    fu_type_t [SLOTS-1:0] out_fu_type;
    alu_op_t [SLOTS-1:0] out_alu_op;
    mem_size_t [SLOTS-1:0] out_mem_size;
    logic [SLOTS-1:0] out_mem_signed;
    logic [SLOTS-1:0] out_mem_write;
    br_cond_t [SLOTS-1:0] out_br_cond;
    logic [SLOTS-1:0] out_syscall;
    logic [SLOTS-1:0] out_break;
    logic [SLOTS-1:0] out_decode_err;

    `include "la_ref_model.svh"

    typedef struct packed {
        logic [SLOTS-1:0]           mask;
        exp_slot_t [SLOTS-1:0]      slot;
    } exp_pkt_t;

    exp_pkt_t    exp_q[$];
    logic [31:0] seed = 32'hc872;
    logic        driving;
    int          n_xfer;
    int          cycles;

    decode_stage decode_stage_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] rnd();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    task automatic check_field(string name, int slot, logic [31:0] got, logic [31:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH at %0t: slot %0d %s got %h expected %h",
                     $time, slot, name, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "decode stage check failed");
        end
    endtask

    task automatic check_slot(int i, exp_slot_t e);
        check_field("pc", i, out_pc[i], e.pc);
        check_field("r0_arfid", i, 32'(out_r_arfid[2*i]), 32'(e.r0));
        check_field("r1_arfid", i, 32'(out_r_arfid[2*i+1]), 32'(e.r1));
        check_field("use_imm", i, 32'({out_use_imm[2*i+1], out_use_imm[2*i]}), 32'(e.use_imm));
        check_field("w_arfid", i, 32'(out_w_arfid[i]), 32'(e.w_id));
        check_field("w_reg", i, 32'(out_w_reg[i]), 32'(e.w_reg));
        check_field("data_imm", i, out_data_imm[i], e.data_imm);
        check_field("addr_imm", i, out_addr_imm[i], e.addr_imm);
        check_field("fu_type", i, 32'(out_fu_type[i]), 32'(e.fu));
        check_field("alu_op", i, 32'(out_alu_op[i]), 32'(e.alu));
        check_field("mem_size", i, 32'(out_mem_size[i]), 32'(e.msize));
        check_field("mem_signed", i, 32'(out_mem_signed[i]), 32'(e.msigned));
        check_field("mem_write", i, 32'(out_mem_write[i]), 32'(e.mwrite));
        check_field("br_cond", i, 32'(out_br_cond[i]), 32'(e.br));
        check_field("syscall", i, 32'(out_syscall[i]), 32'(e.sys));
        check_field("break", i, 32'(out_break[i]), 32'(e.brk));
        check_field("decode_err", i, 32'(out_decode_err[i]), 32'(e.err));
    endtask

    // new inputs land 1 ns after each rising edge
    always @(posedge clk) begin
        logic [31:0] r;
        logic [31:0] r_idx;
        #1;
        if (driving) begin
            r         = rnd();
            in_valid  = (r[31:30] != 2'b00);
            out_ready = (r[29:28] != 2'b00) && (r[27:26] != 2'b00);   // heavy back-pressure
            in_mask   = r[17:16];
            in_pc     = {rnd() & 32'hffff_fff8};
            for (int i = 0; i < SLOTS; i++) begin
                r     = rnd();
                r_idx = rnd();
                if (r[31:29] == 3'b000)
                    in_insts[i] = rnd();   // mostly unsupported
                else
                    in_insts[i] = gen_legal(r_idx, rnd());
            end
        end
    end

    // handshakes sampled mid-cycle belong to the coming edge
    always @(negedge clk) begin
        exp_pkt_t pkt;
        if (driving) begin
            check_field("in_ready", 0, 32'(in_ready), 32'(exp_q.size() < BUF_DEPTH));
            check_field("out_valid", 0, 32'(out_valid), 32'(exp_q.size() != 0));
            if (out_valid && out_ready) begin
                pkt = exp_q.pop_front();
                check_field("mask", 0, 32'(out_mask), 32'(pkt.mask));
                for (int i = 0; i < SLOTS; i++)
                    check_slot(i, pkt.slot[i]);
                n_xfer++;
            end
            if (in_valid && in_ready) begin
                pkt.mask = in_mask;
                for (int i = 0; i < SLOTS; i++)
                    pkt.slot[i] = ref_decode(in_insts[i], in_pc + 32'(4 * i));
                exp_q.push_back(pkt);
            end
        end
    end

    initial begin
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        out_ready   = 1'b0;
        in_pc       = '0;
        in_insts    = '0;
        in_mask     = '0;
        driving     = 1'b0;
        n_xfer      = 0;
        cycles      = 0;
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;
        @(negedge clk);
        check_field("in_ready after reset", 0, 32'(in_ready), 32'd1);
        check_field("out_valid after reset", 0, 32'(out_valid), 32'd0);
        driving = 1'b1;
        while (n_xfer < 2000) begin
            @(posedge clk);
            cycles++;
            if (cycles > 40000) begin
                $display("timeout: only %0d of 2000 bundles arrived", n_xfer);
                $display("SOME TESTS FAILED");
                $fatal(1, "run timed out");
            end
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- build.f
+incdir+bench
hdl/la_isa_pkg.sv
hdl/decode_pkg.sv
hdl/basic_decoder.sv
hdl/imm_gen.sv
hdl/decoder.sv
hdl/decode_ctrl.sv
hdl/decode_stage.sv
bench/decode_stage_tb.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = decode_stage_tb
FILELIST  = build.f
LOG       = sim.log
SIM       = obj_dir/V$(TOP)
SOURCES   = $(wildcard hdl/*.sv) $(wildcard bench/*.sv) $(wildcard bench/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	-./$(SIM) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "ALL TESTS PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
